//--- verilog/ooo_pkg.sv
package ooo_pkg;

    // ========================================
    // Core sizes
    // ========================================
    parameter int XLEN      = 32;
    parameter int NUM_ARCH  = 32;
    parameter int ROB_DEPTH = 16;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      arch_reg_t;
    // Sized for the largest physical file (64 tags)
    typedef logic [5:0]      phys_tag_t;
    typedef logic [3:0]      rob_idx_t;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        ADDI,
        MUL
    } opcode_e;

    // Host instruction word, imm sign-extended at rename
    typedef struct packed {
        opcode_e     opcode;
        arch_reg_t   rd;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
        logic        rsvd;
        logic [11:0] imm;
    } instr_t;

endpackage

//--- verilog/ooo_regs_pkg.sv
package ooo_regs_pkg;

    typedef logic [7:0] reg_addr_t;

    // Host register map
    localparam reg_addr_t INSTR_OFFSET   = 8'h00;
    localparam reg_addr_t STATUS_OFFSET  = 8'h04;
    localparam reg_addr_t RETIRED_OFFSET = 8'h08;
    // Register n at ARF_BASE + 4n
    localparam reg_addr_t ARF_BASE       = 8'h80;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

endpackage

//--- verilog/cdb_if.sv
`timescale 1ns/1ps

// One result per cycle, no back-pressure
interface cdb_if;
    logic               valid;
    ooo_pkg::phys_tag_t tag;
    ooo_pkg::rob_idx_t  rob_idx;
    ooo_pkg::xlen_t     value;

    modport producer (
        output valid, tag, rob_idx, value
    );

    modport consumer (
        input valid, tag, rob_idx, value
    );
endinterface

//--- verilog/dispatch_if.sv
`timescale 1ns/1ps

// Renamed instruction, valid only on accept cycles
interface dispatch_if;
    logic               valid;
    ooo_pkg::opcode_e   op;
    ooo_pkg::phys_tag_t dst_tag;
    ooo_pkg::phys_tag_t old_tag;
    ooo_pkg::arch_reg_t rd;
    logic               has_rd;
    ooo_pkg::phys_tag_t src1_tag;
    ooo_pkg::phys_tag_t src2_tag;
    ooo_pkg::xlen_t     src1_val;
    ooo_pkg::xlen_t     src2_val;
    logic               src1_ready;
    logic               src2_ready;
    ooo_pkg::xlen_t     imm;
    ooo_pkg::rob_idx_t  rob_idx;

    modport driver (
        output valid, op, dst_tag, old_tag, rd, has_rd, src1_tag, src2_tag,
               src1_val, src2_val, src1_ready, src2_ready, imm, rob_idx
    );

    modport receiver (
        input valid, op, dst_tag, old_tag, rd, has_rd, src1_tag, src2_tag,
              src1_val, src2_val, src1_ready, src2_ready, imm, rob_idx
    );
endinterface

//--- verilog/rename_unit.sv
`timescale 1ns/1ps

module rename_unit #(
    parameter int NUM_PHYS = 64
) (
    input  logic               clk,
    input  logic               rst_n,
    input  ooo_pkg::instr_t    instr,
    input  logic               instr_valid,
    input  logic               rob_full,
    input  ooo_pkg::rob_idx_t  rob_tail,
    input  logic               rs_full,
    input  logic               free_en,
    input  ooo_pkg::phys_tag_t free_tag,
    cdb_if.consumer            cdb,
    output logic               instr_accept,
    dispatch_if.driver         disp
);

    // Free list pointers wrap naturally, NUM_PHYS is a power of two
    localparam int PW = $clog2(NUM_PHYS);

    ooo_pkg::phys_tag_t map_table [ooo_pkg::NUM_ARCH];
    ooo_pkg::phys_tag_t fl_mem [NUM_PHYS];
    logic [PW-1:0]      fl_head;
    logic [PW-1:0]      fl_tail;
    logic [PW:0]        fl_count;
    ooo_pkg::xlen_t     prf [NUM_PHYS];
    logic [NUM_PHYS-1:0] busy;
    logic               has_rd;
    logic               pop;
    ooo_pkg::phys_tag_t tag1;
    ooo_pkg::phys_tag_t tag2;

    // Writes to x0 take no tag
    assign has_rd = (instr.rd != '0);
    assign instr_accept = instr_valid && !rob_full && !rs_full && !(has_rd && fl_count == '0);
    assign pop = instr_accept && has_rd;
    assign tag1 = map_table[instr.rs1];
    assign tag2 = map_table[instr.rs2];

    // ========================================
    // Dispatch packet
    // ========================================
    assign disp.valid    = instr_accept;
    assign disp.op       = instr.opcode;
    assign disp.rd       = instr.rd;
    assign disp.has_rd   = has_rd;
    assign disp.dst_tag  = has_rd ? fl_mem[fl_head] : '0;
    assign disp.old_tag  = map_table[instr.rd];
    assign disp.src1_tag = tag1;
    assign disp.src2_tag = tag2;
    // Same-cycle bus result counts as ready
    assign disp.src1_ready = !busy[tag1] || (cdb.valid && cdb.tag == tag1);
    assign disp.src1_val   = busy[tag1] ? cdb.value : prf[tag1];
    // ADDI never waits on rs2
    assign disp.src2_ready = (instr.opcode == ooo_pkg::ADDI) || !busy[tag2] ||
                             (cdb.valid && cdb.tag == tag2);
    assign disp.src2_val   = busy[tag2] ? cdb.value : prf[tag2];
    assign disp.imm        = {{20{instr.imm[11]}}, instr.imm};
    assign disp.rob_idx    = rob_tail;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PHYS; i++) begin
                prf[i]    <= '0;
                fl_mem[i] <= ooo_pkg::phys_tag_t'(i + ooo_pkg::NUM_ARCH);
            end
            for (int i = 0; i < ooo_pkg::NUM_ARCH; i++) begin
                map_table[i] <= ooo_pkg::phys_tag_t'(i);
            end
            busy     <= '0;
            fl_head  <= '0;
            fl_tail  <= PW'(NUM_PHYS - ooo_pkg::NUM_ARCH);
            fl_count <= (PW+1)'(NUM_PHYS - ooo_pkg::NUM_ARCH);
        end else begin
            if (cdb.valid) begin
                busy[cdb.tag] <= 1'b0;
                // Tag 0 stays pinned to x0
                if (cdb.tag != '0) begin
                    prf[cdb.tag] <= cdb.value;
                end
            end
            if (pop) begin
                map_table[instr.rd]    <= fl_mem[fl_head];
                busy[fl_mem[fl_head]]  <= 1'b1;
                fl_head                <= fl_head + 1'b1;
            end
            if (free_en) begin
                fl_mem[fl_tail] <= free_tag;
                fl_tail         <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + (PW+1)'(free_en) - (PW+1)'(pop);
        end
    end

    a_no_empty_pop: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> fl_count != '0)
        else $error("rename_unit: pop from empty free list");

endmodule

//--- verilog/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
    parameter int RS_DEPTH = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    dispatch_if.receiver       disp,
    cdb_if.consumer            cdb,
    input  logic               exec_ready,
    output logic               rs_full,
    output logic               issue_valid,
    output ooo_pkg::opcode_e   issue_op,
    output ooo_pkg::phys_tag_t issue_tag,
    output ooo_pkg::rob_idx_t  issue_rob_idx,
    output ooo_pkg::xlen_t     issue_a,
    output ooo_pkg::xlen_t     issue_b,
    output ooo_pkg::xlen_t     issue_imm
);

    localparam int IW = $clog2(RS_DEPTH);

    typedef struct packed {
        ooo_pkg::opcode_e   op;
        ooo_pkg::phys_tag_t tag;
        ooo_pkg::rob_idx_t  rob_idx;
        ooo_pkg::phys_tag_t a_tag;
        ooo_pkg::phys_tag_t b_tag;
        ooo_pkg::xlen_t     a_val;
        ooo_pkg::xlen_t     b_val;
        ooo_pkg::xlen_t     imm;
        logic               a_rdy;
        logic               b_rdy;
    } rs_entry_t;

    rs_entry_t           ent [RS_DEPTH];
    logic [RS_DEPTH-1:0] ent_valid;
    logic [IW-1:0]       free_sel;
    logic [IW-1:0]       issue_sel;
    logic                free_found;
    logic                issue_found;

    // Lowest free slot and lowest ready slot
    always_comb begin
        free_sel    = '0;
        free_found  = 1'b0;
        issue_sel   = '0;
        issue_found = 1'b0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!ent_valid[i]) begin
                free_sel   = IW'(i);
                free_found = 1'b1;
            end
            if (ent_valid[i] && ent[i].a_rdy && ent[i].b_rdy) begin
                issue_sel   = IW'(i);
                issue_found = 1'b1;
            end
        end
    end

    assign rs_full       = !free_found;
    assign issue_valid   = issue_found && exec_ready;
    assign issue_op      = ent[issue_sel].op;
    assign issue_tag     = ent[issue_sel].tag;
    assign issue_rob_idx = ent[issue_sel].rob_idx;
    assign issue_a       = ent[issue_sel].a_val;
    assign issue_b       = ent[issue_sel].b_val;
    assign issue_imm     = ent[issue_sel].imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ent_valid <= '0;
        end else begin
            if (issue_valid) begin
                ent_valid[issue_sel] <= 1'b0;
            end
            if (disp.valid) begin
                ent_valid[free_sel] <= 1'b1;
            end
        end
    end

    // Wakeup and allocation
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (ent_valid[i] && cdb.valid) begin
                if (!ent[i].a_rdy && cdb.tag == ent[i].a_tag) begin
                    ent[i].a_val <= cdb.value;
                    ent[i].a_rdy <= 1'b1;
                end
                if (!ent[i].b_rdy && cdb.tag == ent[i].b_tag) begin
                    ent[i].b_val <= cdb.value;
                    ent[i].b_rdy <= 1'b1;
                end
            end
        end
        if (disp.valid) begin
            ent[free_sel] <= '{op: disp.op, tag: disp.dst_tag, rob_idx: disp.rob_idx,
                               a_tag: disp.src1_tag, b_tag: disp.src2_tag,
                               a_val: disp.src1_val, b_val: disp.src2_val,
                               imm: disp.imm, a_rdy: disp.src1_ready,
                               b_rdy: disp.src2_ready};
        end
    end

    a_issue_ready: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid |-> ent_valid[issue_sel] && ent[issue_sel].a_rdy && ent[issue_sel].b_rdy)
        else $error("reservation_station: issued entry not ready");

endmodule

//--- verilog/exec_unit.sv
`timescale 1ns/1ps

module exec_unit #(
    parameter int MUL_STAGES = 3
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue_valid,
    input  ooo_pkg::opcode_e   issue_op,
    input  ooo_pkg::phys_tag_t issue_tag,
    input  ooo_pkg::rob_idx_t  issue_rob_idx,
    input  ooo_pkg::xlen_t     issue_a,
    input  ooo_pkg::xlen_t     issue_b,
    input  ooo_pkg::xlen_t     issue_imm,
    output logic               exec_ready,
    cdb_if.producer            cdb
);

    localparam int LAST = MUL_STAGES - 1;

    ooo_pkg::xlen_t      alu_res;
    logic                is_mul;
    logic                alu_v;
    ooo_pkg::phys_tag_t  alu_tag;
    ooo_pkg::rob_idx_t   alu_rob;
    ooo_pkg::xlen_t      alu_val;
    logic [LAST:0]       mul_v;
    ooo_pkg::phys_tag_t  mul_tag [MUL_STAGES];
    ooo_pkg::rob_idx_t   mul_rob [MUL_STAGES];
    ooo_pkg::xlen_t      mul_val [MUL_STAGES];

    assign is_mul = (issue_op == ooo_pkg::MUL);

    always_comb begin
        case (issue_op)
            ooo_pkg::ADD:  alu_res = issue_a + issue_b;
            ooo_pkg::SUB:  alu_res = issue_a - issue_b;
            ooo_pkg::AND:  alu_res = issue_a & issue_b;
            ooo_pkg::OR:   alu_res = issue_a | issue_b;
            ooo_pkg::XOR:  alu_res = issue_a ^ issue_b;
            ooo_pkg::SLL:  alu_res = issue_a << issue_b[4:0];
            ooo_pkg::ADDI: alu_res = issue_a + issue_imm;
            default:       alu_res = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            alu_v <= 1'b0;
            mul_v <= '0;
        end else begin
            alu_v <= issue_valid && !is_mul;
            mul_v <= {mul_v[LAST-1:0], issue_valid && is_mul};
        end
    end

    // Multiplier keeps the low word
    always_ff @(posedge clk) begin
        alu_tag    <= issue_tag;
        alu_rob    <= issue_rob_idx;
        alu_val    <= alu_res;
        mul_tag[0] <= issue_tag;
        mul_rob[0] <= issue_rob_idx;
        mul_val[0] <= issue_a * issue_b;
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_tag[s] <= mul_tag[s-1];
            mul_rob[s] <= mul_rob[s-1];
            mul_val[s] <= mul_val[s-1];
        end
    end

    // Hold issue when a product lands next cycle
    assign exec_ready  = !mul_v[LAST-1];
    assign cdb.valid   = alu_v || mul_v[LAST];
    assign cdb.tag     = mul_v[LAST] ? mul_tag[LAST] : alu_tag;
    assign cdb.rob_idx = mul_v[LAST] ? mul_rob[LAST] : alu_rob;
    assign cdb.value   = mul_v[LAST] ? mul_val[LAST] : alu_val;

    a_one_result: assert property (@(posedge clk) disable iff (!rst_n)
        !(alu_v && mul_v[LAST]))
        else $error("exec_unit: ALU and MUL results collide");

endmodule

//--- verilog/rob.sv
`timescale 1ns/1ps

module rob (
    input  logic               clk,
    input  logic               rst_n,
    dispatch_if.receiver       disp,
    cdb_if.consumer            cdb,
    input  ooo_pkg::arch_reg_t arf_raddr,
    output logic               rob_full,
    output ooo_pkg::rob_idx_t  rob_tail,
    output logic               rob_empty,
    output logic               commit_valid,
    output logic               free_en,
    output ooo_pkg::phys_tag_t free_tag,
    output ooo_pkg::xlen_t     arf_rdata
);

    localparam int DEPTH = ooo_pkg::ROB_DEPTH;
    localparam int CW    = $clog2(DEPTH) + 1;

    logic [DEPTH-1:0]   done;
    logic [DEPTH-1:0]   ent_has_rd;
    ooo_pkg::arch_reg_t ent_rd [DEPTH];
    ooo_pkg::phys_tag_t ent_old_tag [DEPTH];
    ooo_pkg::xlen_t     ent_value [DEPTH];
    ooo_pkg::rob_idx_t  head;
    ooo_pkg::rob_idx_t  tail;
    logic [CW-1:0]      count;
    ooo_pkg::xlen_t     arf [ooo_pkg::NUM_ARCH];

    assign rob_full     = (count == CW'(DEPTH));
    assign rob_empty    = (count == '0);
    assign rob_tail     = tail;
    assign commit_valid = !rob_empty && done[head];
    assign free_en      = commit_valid && ent_has_rd[head];
    assign free_tag     = ent_old_tag[head];
    // x0 always reads zero
    assign arf_rdata    = (arf_raddr == '0) ? '0 : arf[arf_raddr];

    // ========================================
    // Pointers, done bits and commit
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
            for (int i = 0; i < ooo_pkg::NUM_ARCH; i++) begin
                arf[i] <= '0;
            end
        end else begin
            if (cdb.valid) begin
                done[cdb.rob_idx] <= 1'b1;
            end
            if (disp.valid) begin
                done[disp.rob_idx] <= 1'b0;
                tail               <= tail + 1'b1;
            end
            if (commit_valid) begin
                head <= head + 1'b1;
                if (ent_has_rd[head]) begin
                    arf[ent_rd[head]] <= ent_value[head];
                end
            end
            count <= count + CW'(disp.valid) - CW'(commit_valid);
        end
    end

    always_ff @(posedge clk) begin
        if (cdb.valid) begin
            ent_value[cdb.rob_idx] <= cdb.value;
        end
        if (disp.valid) begin
            ent_has_rd[disp.rob_idx]  <= disp.has_rd;
            ent_rd[disp.rob_idx]      <= disp.rd;
            ent_old_tag[disp.rob_idx] <= disp.old_tag;
        end
    end

    // Rename must allocate at the tail and never into a full buffer
    a_alloc_ok: assert property (@(posedge clk) disable iff (!rst_n)
        disp.valid |-> !rob_full && disp.rob_idx == tail)
        else $error("rob: bad allocation");

endmodule

//--- verilog/core_regs.sv
`timescale 1ns/1ps

module core_regs (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ooo_regs_pkg::reg_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  ooo_pkg::xlen_t          wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output ooo_regs_pkg::axi_resp_e bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  ooo_regs_pkg::reg_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output ooo_pkg::xlen_t          rdata,
    output ooo_regs_pkg::axi_resp_e rresp,
    output logic                    rvalid,
    input  logic                    rready,
    input  logic                    commit_valid,
    input  logic                    rob_empty,
    input  ooo_pkg::xlen_t          arf_rdata,
    input  logic                    instr_accept,
    output ooo_pkg::instr_t         instr,
    output logic                    instr_valid,
    output ooo_pkg::arch_reg_t      arf_raddr
);

    logic           wr_hs;
    logic           rd_hs;
    logic           idle;
    ooo_pkg::xlen_t retired;

    // Writes wait while a response or an instruction is outstanding
    assign awready   = !bvalid && !instr_valid;
    assign wready    = awready;
    assign wr_hs     = awvalid && wvalid && awready;
    assign arready   = !rvalid;
    assign rd_hs     = arvalid && arready;
    assign idle      = rob_empty && !instr_valid;
    assign arf_raddr = araddr[6:2];

    // ========================================
    // Write path
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            instr_valid <= 1'b0;
            bvalid      <= 1'b0;
            bresp       <= ooo_regs_pkg::OKAY;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            // Response only once rename takes the instruction
            if (instr_valid && instr_accept) begin
                instr_valid <= 1'b0;
                bvalid      <= 1'b1;
                bresp       <= ooo_regs_pkg::OKAY;
            end
            if (wr_hs) begin
                if (awaddr == ooo_regs_pkg::INSTR_OFFSET) begin
                    instr_valid <= 1'b1;
                end else begin
                    bvalid <= 1'b1;
                    bresp  <= ooo_regs_pkg::SLVERR;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs && awaddr == ooo_regs_pkg::INSTR_OFFSET) begin
            instr <= ooo_pkg::instr_t'(wdata);
        end
    end

    // ========================================
    // Read path and retire count
    // ========================================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid  <= 1'b0;
            retired <= '0;
        end else begin
            if (commit_valid) begin
                retired <= retired + 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rresp <= ooo_regs_pkg::OKAY;
            rdata <= '0;
            if (araddr >= ooo_regs_pkg::ARF_BASE && araddr[1:0] == 2'b00) begin
                rdata <= arf_rdata;
            end else if (araddr == ooo_regs_pkg::STATUS_OFFSET) begin
                rdata <= {31'b0, idle};
            end else if (araddr == ooo_regs_pkg::RETIRED_OFFSET) begin
                rdata <= retired;
            end else begin
                rresp <= ooo_regs_pkg::SLVERR;
            end
        end
    end

    a_instr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid && !instr_accept |=> $stable(instr))
        else $error("core_regs: instr changed while pending");

endmodule

//--- verilog/ooo_core_top.sv
`timescale 1ns/1ps

module ooo_core_top #(
    parameter int NUM_PHYS   = 64,
    parameter int RS_DEPTH   = 8,
    parameter int MUL_STAGES = 3
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ooo_regs_pkg::reg_addr_t awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  ooo_pkg::xlen_t          wdata,
    input  logic                    wvalid,
    output logic                    wready,
    output ooo_regs_pkg::axi_resp_e bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  ooo_regs_pkg::reg_addr_t araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output ooo_pkg::xlen_t          rdata,
    output ooo_regs_pkg::axi_resp_e rresp,
    output logic                    rvalid,
    input  logic                    rready
);

    // ========================================
    // Core interconnect
    // ========================================
    ooo_pkg::instr_t    instr;
    logic               instr_valid;
    logic               instr_accept;
    logic               rob_full;
    ooo_pkg::rob_idx_t  rob_tail;
    logic               rob_empty;
    logic               rs_full;
    logic               free_en;
    ooo_pkg::phys_tag_t free_tag;
    logic               commit_valid;
    ooo_pkg::arch_reg_t arf_raddr;
    ooo_pkg::xlen_t     arf_rdata;
    logic               exec_ready;
    logic               issue_valid;
    ooo_pkg::opcode_e   issue_op;
    ooo_pkg::phys_tag_t issue_tag;
    ooo_pkg::rob_idx_t  issue_rob_idx;
    ooo_pkg::xlen_t     issue_a;
    ooo_pkg::xlen_t     issue_b;
    ooo_pkg::xlen_t     issue_imm;

    cdb_if      cdb ();
    dispatch_if disp ();

    // Names match across the hierarchy
    core_regs u_core_regs (.*);

    rename_unit #(.NUM_PHYS(NUM_PHYS)) u_rename (.*);

    reservation_station #(.RS_DEPTH(RS_DEPTH)) u_rs (.*);

    exec_unit #(.MUL_STAGES(MUL_STAGES)) u_exec (.*);

    rob u_rob (.*);

endmodule

//--- dv/tb_ooo_core.sv
`timescale 1ns/1ps

module tb_ooo_core;

    // Opcode field values of the host instruction format
    localparam logic [3:0] OP_ADD  = 4'd0;
    localparam logic [3:0] OP_SUB  = 4'd1;
    localparam logic [3:0] OP_AND  = 4'd2;
    localparam logic [3:0] OP_OR   = 4'd3;
    localparam logic [3:0] OP_XOR  = 4'd4;
    localparam logic [3:0] OP_SLL  = 4'd5;
    localparam logic [3:0] OP_ADDI = 4'd6;
    localparam logic [3:0] OP_MUL  = 4'd7;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam int ALU_LEN         = 12;
    localparam int MUL_LEN         = 9;
    localparam int RAND_LEN        = 60;
    localparam int TOTAL_INSTR     = ALU_LEN + MUL_LEN + RAND_LEN;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 40 + 2000;

    logic                    clk;
    logic                    rst_n;
    ooo_regs_pkg::reg_addr_t awaddr;
    logic                    awvalid;
    logic                    awready;
    ooo_pkg::xlen_t          wdata;
    logic                    wvalid;
    logic                    wready;
    ooo_regs_pkg::axi_resp_e bresp;
    logic                    bvalid;
    logic                    bready;
    ooo_regs_pkg::reg_addr_t araddr;
    logic                    arvalid;
    logic                    arready;
    ooo_pkg::xlen_t          rdata;
    ooo_regs_pkg::axi_resp_e rresp;
    logic                    rvalid;
    logic                    rready;

    // Reference model and bookkeeping
    logic [31:0] model_regs [32];
    int          pushed;
    logic [15:0] lfsr_state;
    string       cur_test;
    int          test_errors;
    int          total_errors;
    int          checks;
    int          tests_run;
    int          tests_failed;

    ooo_core_top #(.NUM_PHYS(64), .RS_DEPTH(8), .MUL_STAGES(3)) DUT (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // ========================================
    // Helpers
    // ========================================
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        // Taps 16 14 13 11
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %s %s: expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        // Handshake lands on the edge after both readies are seen
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
    endtask

    // In-order execution of one instruction
    task automatic model_exec(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic [11:0] imm);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        a = model_regs[rs1];
        b = model_regs[rs2];
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = a << b[4:0];
            OP_ADDI: res = a + {{20{imm[11]}}, imm};
            OP_MUL:  res = a * b;
            default: res = '0;
        endcase
        if (rd != 5'd0) begin
            model_regs[rd] = res;
        end
        pushed++;
    endtask

    task automatic push_instr(input logic [3:0] op, input logic [4:0] rd, input logic [4:0] rs1,
                              input logic [4:0] rs2, input logic [11:0] imm);
        logic [1:0] resp;
        axi_write(ooo_regs_pkg::INSTR_OFFSET, {op, rd, rs1, rs2, 1'b0, imm}, resp);
        check_value("push response", 32'(RESP_OKAY), 32'(resp));
        model_exec(op, rd, rs1, rs2, imm);
    endtask

    task automatic wait_idle();
        logic [31:0] data;
        logic [1:0]  resp;
        data = '0;
        while (data[0] !== 1'b1) begin
            axi_read(ooo_regs_pkg::STATUS_OFFSET, data, resp);
        end
    endtask

    // Retired count and full register window against the model
    task automatic check_state();
        logic [31:0] data;
        logic [1:0]  resp;
        wait_idle();
        axi_read(ooo_regs_pkg::RETIRED_OFFSET, data, resp);
        check_value("RETIRED", 32'(pushed), data);
        for (int r = 0; r < 32; r++) begin
            axi_read(ooo_regs_pkg::ARF_BASE + 8'(4 * r), data, resp);
            check_value($sformatf("x%0d response", r), 32'(RESP_OKAY), 32'(resp));
            check_value($sformatf("x%0d", r), model_regs[r], data);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("Test %s: done, no errors", cur_test);
        end else begin
            $display("Test %s: done, %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
    endtask

    // ========================================
    // Directed tests
    // ========================================
    task automatic test_reset_state();
        logic [31:0] data;
        logic [1:0]  resp;
        start_test("reset_state");
        axi_read(ooo_regs_pkg::STATUS_OFFSET, data, resp);
        check_value("STATUS", 32'd1, data);
        check_state();
        end_test();
    endtask

    task automatic test_alu_ops();
        start_test("alu_ops");
        push_instr(OP_ADDI, 5'd1, 5'd0, 5'd0, 12'd100);
        push_instr(OP_ADDI, 5'd2, 5'd0, 5'd0, 12'hFF9);
        push_instr(OP_ADDI, 5'd3, 5'd0, 5'd0, 12'h5A5);
        push_instr(OP_ADD,  5'd4, 5'd1, 5'd2, 12'd0);
        push_instr(OP_SUB,  5'd5, 5'd1, 5'd2, 12'd0);
        push_instr(OP_AND,  5'd6, 5'd3, 5'd2, 12'd0);
        push_instr(OP_OR,   5'd7, 5'd3, 5'd1, 12'd0);
        push_instr(OP_XOR,  5'd8, 5'd3, 5'd2, 12'd0);
        push_instr(OP_ADDI, 5'd9, 5'd0, 5'd0, 12'd4);
        push_instr(OP_SLL,  5'd10, 5'd3, 5'd9, 12'd0);
        // x0 must stay zero
        push_instr(OP_ADDI, 5'd0, 5'd1, 5'd0, 12'd55);
        push_instr(OP_ADD,  5'd0, 5'd1, 5'd3, 12'd0);
        check_state();
        end_test();
    endtask

    task automatic test_mul_ooo();
        start_test("mul_out_of_order");
        push_instr(OP_ADDI, 5'd11, 5'd0, 5'd0, 12'd1234);
        push_instr(OP_ADDI, 5'd12, 5'd0, 5'd0, 12'hEBF);
        push_instr(OP_MUL,  5'd13, 5'd11, 5'd12, 12'd0);
        // Independent work behind the multiply
        push_instr(OP_ADDI, 5'd14, 5'd0, 5'd0, 12'd9);
        push_instr(OP_XOR,  5'd15, 5'd11, 5'd14, 12'd0);
        push_instr(OP_SUB,  5'd16, 5'd14, 5'd11, 12'd0);
        push_instr(OP_ADD,  5'd17, 5'd13, 5'd11, 12'd0);
        push_instr(OP_MUL,  5'd18, 5'd13, 5'd13, 12'd0);
        push_instr(OP_SLL,  5'd19, 5'd18, 5'd14, 12'd0);
        check_state();
        end_test();
    endtask

    task automatic test_random_stream();
        logic [31:0] op;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        start_test("random_stream");
        for (int i = 0; i < RAND_LEN; i++) begin
            draw_bits(3, op);
            draw_bits(3, rd);
            draw_bits(3, rs1);
            draw_bits(3, rs2);
            draw_bits(12, imm);
            // Back-to-back multiply pairs
            if (i % 10 == 3 || i % 10 == 4) begin
                op = 32'(OP_MUL);
            end
            push_instr(op[3:0], rd[4:0], rs1[4:0], rs2[4:0], imm[11:0]);
        end
        check_state();
        end_test();
    endtask

    task automatic test_bad_access();
        logic [31:0] data;
        logic [1:0]  resp;
        start_test("bad_access");
        axi_write(ooo_regs_pkg::STATUS_OFFSET, 32'hFFFF_FFFF, resp);
        check_value("STATUS write response", 32'(RESP_SLVERR), 32'(resp));
        axi_read(ooo_regs_pkg::INSTR_OFFSET, data, resp);
        check_value("INSTR read response", 32'(RESP_SLVERR), 32'(resp));
        check_value("INSTR read data", 32'd0, data);
        axi_read(8'h40, data, resp);
        check_value("0x40 read response", 32'(RESP_SLVERR), 32'(resp));
        check_value("0x40 read data", 32'd0, data);
        check_state();
        end_test();
    endtask

    // ========================================
    // Main sequence and watchdog
    // ========================================
    initial begin
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        lfsr_state   = 16'd6;
        pushed       = 0;
        total_errors = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_state();
        test_alu_ops();
        test_mul_ooo();
        test_random_stream();
        test_bad_access();
        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, total_errors);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- build.f
verilog/ooo_pkg.sv
verilog/ooo_regs_pkg.sv
verilog/cdb_if.sv
verilog/dispatch_if.sv
verilog/rename_unit.sv
verilog/reservation_station.sv
verilog/exec_unit.sv
verilog/rob.sv
verilog/core_regs.sv
verilog/ooo_core_top.sv
dv/tb_ooo_core.sv

//--- Bender.yml
package:
  name: ooo_core

sources:
  - verilog/ooo_pkg.sv
  - verilog/ooo_regs_pkg.sv
  - verilog/cdb_if.sv
  - verilog/dispatch_if.sv
  - verilog/rename_unit.sv
  - verilog/reservation_station.sv
  - verilog/exec_unit.sv
  - verilog/rob.sv
  - verilog/core_regs.sv
  - verilog/ooo_core_top.sv
  - target: test
    files:
      - dv/tb_ooo_core.sv
